// File: src/uart_params.svh
// UART parameter header
// widths, register map and the fixed baud divisor shared by
// the serial port RTL and its testbench
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// character and bus widths
`define UART_DATA_W 8
`define UART_BUS_W 16
`define UART_ADDR_W 3
`define UART_DIV_W 10

// clock cycles per bit minus one, any value from 2 to 1023 works
`define UART_BAUD_DIVISOR 7

// register map
`define UART_ADDR_RXDATA 3'd0
`define UART_ADDR_TXDATA 3'd1
`define UART_ADDR_STATUS 3'd2
`define UART_ADDR_CONTROL 3'd3

`endif

// File: src/uart_pkg.sv
// UART type package
// bus request, decoded strobes, control and status images
// shared between the register block, both serial engines and the testbench
`include "uart_params.svh"

package uart_pkg;

  // one transfer as driven by the host
  typedef struct packed {
    logic                    chipselect;
    logic                    read_n;
    logic                    write_n;
    logic                    begintransfer;
    logic [`UART_ADDR_W-1:0] address;
    logic [`UART_BUS_W-1:0]  writedata;
  } bus_req_t;

  // decoded register strobes, not yet qualified by begintransfer
  typedef struct packed {
    logic rx_rd;
    logic tx_wr;
    logic status_wr;
  } reg_strobes_t;

  typedef struct packed {
    logic force_break;
    logic ie_any_error;
    logic ie_rx_char_ready;
    logic ie_tx_ready;
    logic ie_tx_shift_empty;
    logic ie_tx_overrun;
    logic ie_rx_overrun;
    logic ie_break_detect;
    logic ie_framing_error;
    logic ie_parity_error;
  } control_t;

  typedef struct packed {
    logic tx_ready;
    logic tx_shift_empty;
    logic tx_overrun;
  } tx_status_t;

  typedef struct packed {
    logic rx_char_ready;
    logic rx_overrun;
    logic break_detect;
    logic framing_error;
  } rx_status_t;

  // status register as seen on the bus
  typedef struct packed {
    logic eop;
    logic cts;
    logic dcts;
    logic rsvd;
    logic any_error;
    logic rx_char_ready;
    logic tx_ready;
    logic tx_shift_empty;
    logic tx_overrun;
    logic rx_overrun;
    logic break_detect;
    logic framing_error;
    logic parity_error;
  } status_t;

endpackage

// File: src/uart_tx.sv
// UART transmitter
// loads an 8N1 frame after a transmit write and shifts it out
// lsb first at the fixed baud rate, with ready, empty and overrun
// flags and a force-break override on the line
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx (
  input  logic                    clk,
  input  logic                    reset_n,
  input  uart_pkg::bus_req_t      bus,
  input  uart_pkg::reg_strobes_t  strobes,
  input  logic [`UART_DATA_W-1:0] tx_data,
  input  logic                    force_break,
  output uart_pkg::tx_status_t    tx_status,
  output logic                    txd
);

  localparam int frame_w = `UART_DATA_W + 2;
  localparam logic [`UART_DIV_W-1:0] divisor = `UART_BAUD_DIVISOR;

  logic                    tx_wr_onset;
  logic                    tx_ready;
  logic                    tx_overrun;
  logic                    tx_shift_empty;
  logic                    do_load_shifter;
  logic                    shift_done;
  logic                    do_shift;
  logic                    baud_clk_en;
  logic [`UART_DIV_W-1:0]  baud_count;
  logic [frame_w-1:0]      tx_sr;
  logic                    pre_txd;

  assign tx_wr_onset = strobes.tx_wr && bus.begintransfer;
  // shifter drains toward zero, so all-zero means the frame is gone
  assign shift_done = ~(|tx_sr);
  assign do_shift = baud_clk_en && !shift_done && !do_load_shifter;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      do_load_shifter <= 1'b0;
      tx_ready <= 1'b1;
      tx_overrun <= 1'b0;
      tx_shift_empty <= 1'b1;
    end
    else
    begin
      do_load_shifter <= !tx_ready && shift_done;
      if (tx_wr_onset)
        tx_ready <= 1'b0;
      else if (do_load_shifter)
        tx_ready <= 1'b1;
      // status write wins over a new overrun
      if (strobes.status_wr)
        tx_overrun <= 1'b0;
      else if (!tx_ready && tx_wr_onset)
        tx_overrun <= 1'b1;
      tx_shift_empty <= tx_ready && shift_done;
    end
  end

  // baud tick, restarted with each new frame
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      baud_count <= '0;
      baud_clk_en <= 1'b0;
    end
    else
    begin
      if (baud_count == '0 || do_load_shifter)
        baud_count <= divisor;
      else
        baud_count <= baud_count - 1'b1;
      baud_clk_en <= (baud_count == '0);
    end
  end

  // frame is stop, data, start from msb down
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      tx_sr <= '0;
    else if (do_load_shifter)
      tx_sr <= {1'b1, tx_data, 1'b0};
    else if (do_shift)
      tx_sr <= {1'b0, tx_sr[frame_w-1:1]};
  end

  // two output stages; pre_txd holds the stop level once drained
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      pre_txd <= 1'b1;
      txd <= 1'b1;
    end
    else
    begin
      if (!shift_done)
        pre_txd <= tx_sr[0];
      txd <= pre_txd && !force_break;
    end
  end

  assign tx_status.tx_ready = tx_ready;
  assign tx_status.tx_shift_empty = tx_shift_empty;
  assign tx_status.tx_overrun = tx_overrun;

endmodule

// File: src/uart_rx.sv
// UART receiver
// synchronizes rxd, starts a frame on a falling edge when idle and
// samples each bit near its middle; reports the character with
// char ready, overrun, break and framing error flags
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx (
  input  logic                    clk,
  input  logic                    reset_n,
  input  uart_pkg::bus_req_t      bus,
  input  uart_pkg::reg_strobes_t  strobes,
  input  logic                    rxd,
  output uart_pkg::rx_status_t    rx_status,
  output logic [`UART_DATA_W-1:0] rx_data
);

  localparam int frame_w = `UART_DATA_W + 2;
  localparam logic [`UART_DIV_W-1:0] divisor = `UART_BAUD_DIVISOR;
  localparam logic [`UART_DIV_W-1:0] half_divisor = {1'b0, divisor[`UART_DIV_W-1:1]};

  logic                    rxd_meta;
  logic                    sync_rxd;
  logic                    sync_rxd_d;
  logic                    rxd_edge;
  logic                    rxd_falling;
  logic [`UART_DIV_W-1:0]  baud_count;
  logic [`UART_DIV_W-1:0]  baud_load;
  logic                    baud_clk_en;
  logic                    sample_enable;
  logic                    do_start_rx;
  logic [frame_w-1:0]      rx_sr;
  logic                    rx_in_process;
  logic                    rx_in_process_d;
  logic                    got_new_char;
  logic                    stop_bit;
  logic                    is_break;
  logic                    is_framing_error;
  logic                    rx_rd_onset;
  logic                    rx_char_ready;
  logic                    rx_overrun;
  logic                    break_detect;
  logic                    framing_error;

  // two stage synchronizer plus one delay for edge detection
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rxd_meta <= 1'b1;
      sync_rxd <= 1'b1;
      sync_rxd_d <= 1'b1;
    end
    else
    begin
      rxd_meta <= rxd;
      sync_rxd <= rxd_meta;
      sync_rxd_d <= sync_rxd;
    end
  end

  assign rxd_edge = sync_rxd ^ sync_rxd_d;
  assign rxd_falling = !sync_rxd && sync_rxd_d;

  // any line edge realigns the sample point to half a bit later
  assign baud_load = rxd_edge ? half_divisor : divisor;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      baud_count <= '0;
      baud_clk_en <= 1'b0;
    end
    else
    begin
      if (baud_count == '0 || rxd_edge)
        baud_count <= baud_load;
      else
        baud_count <= baud_count - 1'b1;
      baud_clk_en <= !rxd_edge && (baud_count == '0);
    end
  end

  // start bit marker sits in bit 0 once all ten samples are in
  assign rx_in_process = rx_sr[0];
  assign sample_enable = baud_clk_en && rx_in_process;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      do_start_rx <= 1'b0;
      rx_sr <= '0;
      rx_in_process_d <= 1'b0;
    end
    else
    begin
      do_start_rx <= !rx_in_process && rxd_falling;
      if (do_start_rx)
        rx_sr <= '1;
      else if (sample_enable)
        rx_sr <= {sync_rxd, rx_sr[frame_w-1:1]};
      rx_in_process_d <= rx_in_process;
    end
  end

  assign got_new_char = !rx_in_process && rx_in_process_d;
  assign stop_bit = rx_sr[frame_w-1];
  assign is_break = ~(|rx_sr);
  assign is_framing_error = !stop_bit && !is_break;
  assign rx_rd_onset = strobes.rx_rd && bus.begintransfer;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      rx_data <= '0;
    else if (got_new_char)
      rx_data <= rx_sr[frame_w-2:1];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rx_char_ready <= 1'b0;
      rx_overrun <= 1'b0;
      break_detect <= 1'b0;
      framing_error <= 1'b0;
    end
    else
    begin
      if (rx_rd_onset)
        rx_char_ready <= 1'b0;
      else if (got_new_char)
        rx_char_ready <= 1'b1;
      // sticky error flags, all cleared by a status write
      if (strobes.status_wr)
      begin
        rx_overrun <= 1'b0;
        break_detect <= 1'b0;
        framing_error <= 1'b0;
      end
      else if (got_new_char)
      begin
        if (rx_char_ready)
          rx_overrun <= 1'b1;
        if (is_break)
          break_detect <= 1'b1;
        if (is_framing_error)
          framing_error <= 1'b1;
      end
    end
  end

  assign rx_status.rx_char_ready = rx_char_ready;
  assign rx_status.rx_overrun = rx_overrun;
  assign rx_status.break_detect = break_detect;
  assign rx_status.framing_error = framing_error;

endmodule

// File: src/uart_regs.sv
// UART register block
// decodes the host bus into strobes, holds the transmit data and
// control registers, assembles the status word, registers the read
// data and forms the maskable interrupt
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_regs (
  input  logic                    clk,
  input  logic                    reset_n,
  input  uart_pkg::bus_req_t      bus,
  input  uart_pkg::tx_status_t    tx_status,
  input  uart_pkg::rx_status_t    rx_status,
  input  logic [`UART_DATA_W-1:0] rx_data,
  output uart_pkg::reg_strobes_t  strobes,
  output logic [`UART_DATA_W-1:0] tx_data,
  output logic                    force_break,
  output logic [`UART_BUS_W-1:0]  readdata,
  output logic                    irq,
  output logic                    dataavailable,
  output logic                    readyfordata
);

  import uart_pkg::*;

  logic                   bus_rd;
  logic                   bus_wr;
  logic                   control_wr;
  control_t               control_reg;
  status_t                status_img;
  logic [`UART_BUS_W-1:0] read_mux;
  logic                   irq_next;

  assign bus_rd = bus.chipselect && !bus.read_n;
  assign bus_wr = bus.chipselect && !bus.write_n;

  assign strobes.rx_rd = bus_rd && (bus.address == `UART_ADDR_RXDATA);
  assign strobes.tx_wr = bus_wr && (bus.address == `UART_ADDR_TXDATA);
  assign strobes.status_wr = bus_wr && (bus.address == `UART_ADDR_STATUS);
  assign control_wr = bus_wr && (bus.address == `UART_ADDR_CONTROL);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      tx_data <= '0;
      control_reg <= '0;
    end
    else
    begin
      if (strobes.tx_wr)
        tx_data <= bus.writedata[`UART_DATA_W-1:0];
      if (control_wr)
        control_reg <= bus.writedata[$bits(control_t)-1:0];
    end
  end

  assign force_break = control_reg.force_break;

  // parity is not implemented, so its bit always reads 0
  always_comb
  begin
    status_img = '0;
    status_img.rx_char_ready = rx_status.rx_char_ready;
    status_img.tx_ready = tx_status.tx_ready;
    status_img.tx_shift_empty = tx_status.tx_shift_empty;
    status_img.tx_overrun = tx_status.tx_overrun;
    status_img.rx_overrun = rx_status.rx_overrun;
    status_img.break_detect = rx_status.break_detect;
    status_img.framing_error = rx_status.framing_error;
    status_img.any_error = tx_status.tx_overrun || rx_status.rx_overrun ||
                           rx_status.break_detect || rx_status.framing_error;
  end

  // read data follows the address every cycle
  always_comb
  begin
    read_mux = '0;
    case (bus.address)
      `UART_ADDR_RXDATA:  read_mux[`UART_DATA_W-1:0] = rx_data;
      `UART_ADDR_TXDATA:  read_mux[`UART_DATA_W-1:0] = tx_data;
      `UART_ADDR_STATUS:  read_mux[$bits(status_t)-1:0] = status_img;
      `UART_ADDR_CONTROL: read_mux[$bits(control_t)-1:0] = control_reg;
      default:            read_mux = '0;
    endcase
  end

  assign irq_next =
    (control_reg.ie_any_error      && status_img.any_error)      ||
    (control_reg.ie_rx_char_ready  && status_img.rx_char_ready)  ||
    (control_reg.ie_tx_ready       && status_img.tx_ready)       ||
    (control_reg.ie_tx_shift_empty && status_img.tx_shift_empty) ||
    (control_reg.ie_tx_overrun     && status_img.tx_overrun)     ||
    (control_reg.ie_rx_overrun     && status_img.rx_overrun)     ||
    (control_reg.ie_break_detect   && status_img.break_detect)   ||
    (control_reg.ie_framing_error  && status_img.framing_error);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      readdata <= '0;
      irq <= 1'b0;
      dataavailable <= 1'b0;
      readyfordata <= 1'b0;
    end
    else
    begin
      readdata <= read_mux;
      irq <= irq_next;
      dataavailable <= rx_status.rx_char_ready;
      readyfordata <= tx_status.tx_ready;
    end
  end

endmodule

// File: src/uart.sv
// UART top level
// memory-mapped serial port with a 16-bit register bus, an 8N1
// transmitter and a mid-bit sampling receiver
`timescale 1ns/1ps
`include "uart_params.svh"

module uart (
  input  logic                   clk,
  input  logic                   reset_n,
  input  uart_pkg::bus_req_t     bus,
  input  logic                   rxd,
  output logic [`UART_BUS_W-1:0] readdata,
  output logic                   irq,
  output logic                   dataavailable,
  output logic                   readyfordata,
  output logic                   txd
);

  import uart_pkg::*;

  reg_strobes_t            strobes;
  tx_status_t              tx_status;
  rx_status_t              rx_status;
  logic [`UART_DATA_W-1:0] tx_data;
  logic [`UART_DATA_W-1:0] rx_data;
  logic                    force_break;

  uart_tx u_tx (
    .clk         (clk),
    .reset_n     (reset_n),
    .bus         (bus),
    .strobes     (strobes),
    .tx_data     (tx_data),
    .force_break (force_break),
    .tx_status   (tx_status),
    .txd         (txd)
  );

  uart_rx u_rx (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus       (bus),
    .strobes   (strobes),
    .rxd       (rxd),
    .rx_status (rx_status),
    .rx_data   (rx_data)
  );

  uart_regs u_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .bus           (bus),
    .tx_status     (tx_status),
    .rx_status     (rx_status),
    .rx_data       (rx_data),
    .strobes       (strobes),
    .tx_data       (tx_data),
    .force_break   (force_break),
    .readdata      (readdata),
    .irq           (irq),
    .dataavailable (dataavailable),
    .readyfordata  (readyfordata)
  );

endmodule

// File: testbench/tb_clock_gen.sv
// testbench clock and reset source
// free running clock and an active low reset held for a few cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic reset_n
);

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial
  begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

// File: testbench/tb_uart_checker.sv
// UART testbench checker
// compares register reads with the expected words, keeps dataavailable
// and readyfordata in step with the status image and checks irq
// against the masked OR of the model flags while the model is stable
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart_checker (
  input  logic                   clk,
  input  logic                   reset_n,
  input  uart_pkg::bus_req_t     bus,
  input  logic [`UART_BUS_W-1:0] readdata,
  input  logic                   irq,
  input  logic                   dataavailable,
  input  logic                   readyfordata,
  input  logic                   txd,
  input  logic                   read_check,
  input  logic [`UART_BUS_W-1:0] read_want,
  input  logic [`UART_BUS_W-1:0] read_mask,
  input  uart_pkg::status_t      model_status,
  input  uart_pkg::control_t     model_control,
  input  logic                   irq_check,
  output int                     error_count
);

  import uart_pkg::*;

  logic                   read_pending;
  logic [`UART_BUS_W-1:0] pend_want;
  logic [`UART_BUS_W-1:0] pend_mask;
  logic [`UART_ADDR_W-1:0] pend_addr;
  logic                   status_seen;
  logic [$bits(status_t)+$bits(control_t):0] prev_model;
  int                     stable_cycles;
  logic                   irq_due;
  logic                   irq_want;
  status_t                seen;

  // each enable bit masks the flag of the same name
  function automatic logic irq_expect(input status_t s, input control_t c);
    logic [7:0] flags;
    logic [7:0] enables;
    flags = {s.any_error, s.rx_char_ready, s.tx_ready, s.tx_shift_empty,
             s.tx_overrun, s.rx_overrun, s.break_detect, s.framing_error};
    enables = {c.ie_any_error, c.ie_rx_char_ready, c.ie_tx_ready, c.ie_tx_shift_empty,
               c.ie_tx_overrun, c.ie_rx_overrun, c.ie_break_detect, c.ie_framing_error};
    irq_expect = |(flags & enables);
  endfunction

  // what the DUT sampled at this edge
  always @(posedge clk)
  begin
    read_pending <= reset_n && read_check;
    pend_want <= read_want;
    pend_mask <= read_mask;
    pend_addr <= bus.address;
    status_seen <= reset_n && (bus.address == `UART_ADDR_STATUS);
    if ({model_status, model_control, irq_check} != prev_model)
      stable_cycles <= 0;
    else if (stable_cycles < 3)
      stable_cycles <= stable_cycles + 1;
    prev_model <= {model_status, model_control, irq_check};
    // model unchanged over two edges before irq is judged
    irq_due <= irq_check && ({model_status, model_control, irq_check} == prev_model) &&
               (stable_cycles >= 1);
    irq_want <= irq_expect(model_status, model_control);
  end

  always @(negedge clk)
  begin
    if (reset_n)
    begin
      if (read_pending && ((readdata & pend_mask) != (pend_want & pend_mask)))
      begin
        error_count = error_count + 1;
        $display("[ERROR] t=%0t read of address %0d returned %h, expected %h (mask %h)",
                 $time, pend_addr, readdata, pend_want, pend_mask);
      end
      if (status_seen)
      begin
        seen = status_t'(readdata[$bits(status_t)-1:0]);
        if (dataavailable !== seen.rx_char_ready)
        begin
          error_count = error_count + 1;
          $display("[ERROR] t=%0t dataavailable %b but status rx_char_ready %b",
                   $time, dataavailable, seen.rx_char_ready);
        end
        if (readyfordata !== seen.tx_ready)
        begin
          error_count = error_count + 1;
          $display("[ERROR] t=%0t readyfordata %b but status tx_ready %b",
                   $time, readyfordata, seen.tx_ready);
        end
      end
      if (irq_due && (irq !== irq_want))
      begin
        error_count = error_count + 1;
        $display("[ERROR] t=%0t irq is %b, expected %b", $time, irq, irq_want);
      end
      if (irq_due && (txd !== 1'b1))
      begin
        error_count = error_count + 1;
        $display("[ERROR] t=%0t txd is %b while the line should idle high", $time, txd);
      end
    end
  end

endmodule

// File: testbench/tb_uart.sv
// UART testbench top
// drives the register bus, loops txd back or bit-bangs rxd, keeps a
// model of the registers and flags and hands expectations to the checker
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart;

  import uart_pkg::*;

  localparam int bit_cycles = `UART_BAUD_DIVISOR + 1;
  localparam int loop_bytes = 50;
  localparam int frame_count = loop_bytes + 10;
  localparam int control_trials = 20;
  localparam int poll_limit = 40 * bit_cycles;
  localparam logic [15:0] rx_ready_bit = 16'h0080;
  localparam logic [15:0] tx_empty_bit = 16'h0020;
  localparam logic [15:0] rx_overrun_bit = 16'h0008;
  // frames x bits x cycles per bit x 4 plus margin in 10 ns cycles
  localparam longint timeout_ns =
    (longint'(frame_count) * 10 * bit_cycles * 4 + 10000) * 10;

  logic                   clk;
  logic                   reset_n;
  bus_req_t               bus;
  logic                   rxd;
  logic                   bang_rxd;
  logic                   loop_sel;
  logic [`UART_BUS_W-1:0] readdata;
  logic                   irq;
  logic                   dataavailable;
  logic                   readyfordata;
  logic                   txd;
  logic                   read_check;
  logic [`UART_BUS_W-1:0] read_want;
  logic [`UART_BUS_W-1:0] read_mask;
  status_t                model_status;
  control_t               model_control;
  logic                   irq_check;
  int                     check_errors;
  int                     other_errors;
  // model flags for an idle transmitter
  logic                   m_rx_ready;
  logic                   m_tx_ovr;
  logic                   m_rx_ovr;
  logic                   m_brk;
  logic                   m_frm;

  assign rxd = loop_sel ? txd : bang_rxd;

  tb_clock_gen clock_gen (
    .clk     (clk),
    .reset_n (reset_n)
  );

  uart UUT (
    .clk           (clk),
    .reset_n       (reset_n),
    .bus           (bus),
    .rxd           (rxd),
    .readdata      (readdata),
    .irq           (irq),
    .dataavailable (dataavailable),
    .readyfordata  (readyfordata),
    .txd           (txd)
  );

  tb_uart_checker monitor (
    .clk           (clk),
    .reset_n       (reset_n),
    .bus           (bus),
    .readdata      (readdata),
    .irq           (irq),
    .dataavailable (dataavailable),
    .readyfordata  (readyfordata),
    .txd           (txd),
    .read_check    (read_check),
    .read_want     (read_want),
    .read_mask     (read_mask),
    .model_status  (model_status),
    .model_control (model_control),
    .irq_check     (irq_check),
    .error_count   (check_errors)
  );

  function automatic bus_req_t make_req(input logic rd, input logic wr,
                                        input logic [2:0] addr, input logic [15:0] data);
    bus_req_t req;
    req.chipselect = rd || wr;
    req.read_n = !rd;
    req.write_n = !wr;
    req.begintransfer = rd || wr;
    req.address = addr;
    req.writedata = data;
    make_req = req;
  endfunction

  function automatic status_t status_image();
    status_t s;
    s = '0;
    s.rx_char_ready = m_rx_ready;
    s.tx_ready = 1'b1;
    s.tx_shift_empty = 1'b1;
    s.tx_overrun = m_tx_ovr;
    s.rx_overrun = m_rx_ovr;
    s.break_detect = m_brk;
    s.framing_error = m_frm;
    s.any_error = m_tx_ovr || m_rx_ovr || m_brk || m_frm;
    status_image = s;
  endfunction

  task automatic bus_write(input logic [2:0] addr, input logic [15:0] data);
    @(posedge clk);
    bus <= make_req(1'b0, 1'b1, addr, data);
    if (addr == `UART_ADDR_CONTROL)
      model_control <= control_t'(data[$bits(control_t)-1:0]);
    @(posedge clk);
    bus <= make_req(1'b0, 1'b0, addr, 16'h0);
  endtask

  // a zero mask reads without checking
  task automatic bus_read(input logic [2:0] addr, input logic [15:0] want,
                          input logic [15:0] mask, output logic [15:0] data);
    @(posedge clk);
    bus <= make_req(1'b1, 1'b0, addr, 16'h0);
    read_check <= (mask != 16'h0);
    read_want <= want;
    read_mask <= mask;
    @(posedge clk);
    bus <= make_req(1'b0, 1'b0, addr, 16'h0);
    read_check <= 1'b0;
    @(negedge clk);
    data = readdata;
  endtask

  // second write lands on the cycle after the first
  task automatic write_tx_twice(input logic [7:0] first, input logic [7:0] second);
    @(posedge clk);
    bus <= make_req(1'b0, 1'b1, `UART_ADDR_TXDATA, {8'h00, first});
    @(posedge clk);
    bus <= make_req(1'b0, 1'b1, `UART_ADDR_TXDATA, {8'h00, second});
    @(posedge clk);
    bus <= make_req(1'b0, 1'b0, `UART_ADDR_TXDATA, 16'h0);
  endtask

  task automatic poll_status(input logic [15:0] mask, input logic [15:0] value,
                             input string what);
    logic [15:0] word;
    int tries;
    bus_read(`UART_ADDR_STATUS, 16'h0, 16'h0, word);
    tries = 1;
    while (((word & mask) != value) && (tries < poll_limit))
    begin
      bus_read(`UART_ADDR_STATUS, 16'h0, 16'h0, word);
      tries = tries + 1;
    end
    if ((word & mask) != value)
    begin
      other_errors = other_errors + 1;
      $display("status poll gave up waiting for %s after %0d reads", what, tries);
    end
  endtask

  task automatic check_status();
    logic [15:0] word;
    poll_status(tx_empty_bit, tx_empty_bit, "the transmitter to go idle");
    bus_read(`UART_ADDR_STATUS, {3'b000, status_image()}, 16'hffff, word);
  endtask

  // start bit, data lsb first, chosen stop bit, then idle
  task automatic bang_frame(input logic [7:0] data, input logic stop);
    logic [9:0] frame;
    frame = {stop, data, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      bang_rxd <= frame[i];
      repeat (bit_cycles - 1) @(posedge clk);
    end
    @(posedge clk);
    bang_rxd <= 1'b1;
    repeat (2 * bit_cycles) @(posedge clk);
  endtask

  task automatic loop_byte(input logic [7:0] data);
    logic [15:0] word;
    bus_write(`UART_ADDR_TXDATA, {8'h00, data});
    bus_read(`UART_ADDR_TXDATA, {8'h00, data}, 16'hffff, word);
    poll_status(rx_ready_bit, rx_ready_bit, "a received character");
    bus_read(`UART_ADDR_RXDATA, {8'h00, data}, 16'hffff, word);
    check_status();
  endtask

  initial
  begin
    #(timeout_ns);
    $display("watchdog expired, the test did not finish within %0d ns", timeout_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    logic [15:0] word;
    logic [7:0]  byte_a;
    logic [7:0]  byte_b;
    logic [15:0] ctrl;
    void'($urandom(32'h7667));
    bus = make_req(1'b0, 1'b0, 3'd0, 16'h0);
    bang_rxd = 1'b1;
    loop_sel = 1'b1;
    read_check = 1'b0;
    read_want = '0;
    read_mask = '0;
    model_status = '0;
    model_control = '0;
    irq_check = 1'b0;
    other_errors = 0;
    m_rx_ready = 1'b0;
    m_tx_ovr = 1'b0;
    m_rx_ovr = 1'b0;
    m_brk = 1'b0;
    m_frm = 1'b0;
    @(posedge reset_n);

    // reset values while irq and txd are watched
    @(posedge clk);
    model_status <= status_image();
    irq_check <= 1'b1;
    bus_read(`UART_ADDR_STATUS, 16'h0060, 16'hffff, word);
    bus_read(`UART_ADDR_CONTROL, 16'h0000, 16'hffff, word);
    bus_read(`UART_ADDR_TXDATA, 16'h0000, 16'hffff, word);
    @(posedge clk);
    irq_check <= 1'b0;

    for (int i = 0; i < loop_bytes; i++)
      loop_byte(8'($urandom));

    // transmit overrun
    byte_a = 8'($urandom);
    byte_b = 8'($urandom);
    write_tx_twice(byte_a, byte_b);
    m_tx_ovr = 1'b1;
    bus_read(`UART_ADDR_TXDATA, {8'h00, byte_b}, 16'hffff, word);
    poll_status(rx_ready_bit, rx_ready_bit, "the overrun character");
    bus_read(`UART_ADDR_RXDATA, {8'h00, byte_b}, 16'hffff, word);
    check_status();
    // receive overrun from two characters without a read between
    bus_write(`UART_ADDR_TXDATA, {8'h00, byte_a});
    poll_status(rx_ready_bit, rx_ready_bit, "the first character");
    poll_status(tx_empty_bit, tx_empty_bit, "the transmitter to go idle");
    bus_write(`UART_ADDR_TXDATA, {8'h00, byte_b});
    poll_status(rx_overrun_bit, rx_overrun_bit, "the receive overrun");
    m_rx_ovr = 1'b1;
    bus_read(`UART_ADDR_RXDATA, {8'h00, byte_b}, 16'hffff, word);
    check_status();
    bus_write(`UART_ADDR_STATUS, 16'($urandom));
    m_tx_ovr = 1'b0;
    m_rx_ovr = 1'b0;
    check_status();

    // framing error from a bit-banged frame with stop bit 0
    @(posedge clk);
    loop_sel <= 1'b0;
    byte_a = 8'($urandom) | 8'h10;
    bang_frame(byte_a, 1'b0);
    poll_status(rx_ready_bit, rx_ready_bit, "the bit-banged character");
    m_rx_ready = 1'b1;
    m_frm = 1'b1;
    check_status();
    bus_read(`UART_ADDR_RXDATA, {8'h00, byte_a}, 16'hffff, word);
    m_rx_ready = 1'b0;
    bus_write(`UART_ADDR_STATUS, 16'h0000);
    m_frm = 1'b0;
    check_status();

    // break from force_break holding the looped line low
    @(posedge clk);
    loop_sel <= 1'b1;
    bus_write(`UART_ADDR_CONTROL, 16'h0200);
    poll_status(rx_ready_bit, rx_ready_bit, "the break character");
    m_rx_ready = 1'b1;
    m_brk = 1'b1;
    check_status();
    bus_write(`UART_ADDR_CONTROL, 16'h0000);
    bus_read(`UART_ADDR_RXDATA, 16'h0000, 16'hffff, word);
    m_rx_ready = 1'b0;

    // random interrupt enables while break_detect is still pending
    @(posedge clk);
    model_status <= status_image();
    irq_check <= 1'b1;
    for (int t = 0; t < control_trials; t++)
    begin
      ctrl = 16'($urandom) & 16'hfdff;
      bus_write(`UART_ADDR_CONTROL, ctrl);
      repeat (4) @(posedge clk);
      bus_read(`UART_ADDR_CONTROL, ctrl & 16'h01ff, 16'hffff, word);
    end
    @(posedge clk);
    irq_check <= 1'b0;

    repeat (4) @(posedge clk);
    $display("error counts: %0d compare, %0d other", check_errors, other_errors);
    if ((check_errors == 0) && (other_errors == 0))
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: uart.f
+incdir+src
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart.sv
testbench/tb_clock_gen.sv
testbench/tb_uart_checker.sv
testbench/tb_uart.sv

// File: run.sh
#!/usr/bin/env bash
# build the UART testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -Wno-fatal -f uart.f --top-module tb_uart -o tb_uart_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_uart_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST PASS" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1
